// ==== flist.f ====
+incdir+include
rtl/decode_pkg.sv
rtl/instr_buffer.sv
rtl/decoder_2ri14.sv
rtl/decoder_2ri12.sv
rtl/decoder_3r.sv
rtl/decode_output_stage.sv
rtl/decode_top.sv
tb/decode_tb.sv

// ==== include/la32_opcodes.svh ====
`ifndef LA32_OPCODES_SVH
`define LA32_OPCODES_SVH

// 2RI14 format, opcode in bits 31..24
`define LA32_OP_LL_W    8'h20
`define LA32_OP_SC_W    8'h21

// 2RI12 format, opcode in bits 31..22
`define LA32_OP_SLTI    10'h008
`define LA32_OP_SLTUI   10'h009
`define LA32_OP_ADDI_W  10'h00a
`define LA32_OP_ANDI    10'h00d
`define LA32_OP_ORI     10'h00e
`define LA32_OP_XORI    10'h00f
`define LA32_OP_LD_W    10'h0a2
`define LA32_OP_ST_W    10'h0a6

// 3R format, opcode in bits 31..15
`define LA32_OP_ADD_W   17'h00020
`define LA32_OP_SUB_W   17'h00022
`define LA32_OP_SLT     17'h00024
`define LA32_OP_SLTU    17'h00025
`define LA32_OP_AND     17'h00029
`define LA32_OP_OR      17'h0002a
`define LA32_OP_XOR     17'h0002b

`endif

// ==== rtl/decode_output_stage.sv ====
`default_nettype none

module decode_output_stage (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     head_valid_i,
    input  decode_pkg::pc_t          head_pc_i,
    input  decode_pkg::dec_result_t  res_2ri14_i,
    input  decode_pkg::dec_result_t  res_2ri12_i,
    input  decode_pkg::dec_result_t  res_3r_i,
    output logic                     head_ready_o,
    output logic                     dec_valid_o,
    output decode_pkg::decoded_pkt_t dec_pkt_o,
    input  logic                     dec_ready_i
);

    import decode_pkg::*;

    dec_result_t  merged;
    decoded_pkt_t next_pkt;
    logic         load;

    // decoders are mutually exclusive and zero on a miss, so OR is enough
    assign merged = dec_result_t'(res_2ri14_i | res_2ri12_i | res_3r_i);

    // a miss leaves every decode field zero already
    always_comb begin
        next_pkt          = '0;
        next_pkt.pc       = head_pc_i;
        next_pkt.illegal  = !merged.hit;
        next_pkt.rj_valid = merged.rj_valid;
        next_pkt.rk_valid = merged.rk_valid;
        next_pkt.rj       = merged.rj;
        next_pkt.rk       = merged.rk;
        next_pkt.imm      = merged.imm;
        next_pkt.wr_valid = merged.wr_valid;
        next_pkt.rd       = merged.rd;
        next_pkt.aluop    = merged.aluop;
        next_pkt.alusel   = merged.alusel;
    end

    // take a new head if the register is empty or drains this cycle
    assign head_ready_o = !dec_valid_o || dec_ready_i;
    assign load         = head_valid_i && head_ready_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dec_valid_o <= 1'b0;
        end else if (load) begin
            dec_valid_o <= 1'b1;
        end else if (dec_ready_i) begin
            dec_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            dec_pkt_o <= next_pkt;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    // widths fixed by the LA32 instruction set
    typedef logic [31:0] instr_t;
    typedef logic [31:0] pc_t;
    typedef logic [31:0] data_t;
    typedef logic [4:0]  gpr_addr_t;
    typedef logic [7:0]  alu_op_t;
    typedef logic [2:0]  alu_sel_t;

    // alu operation codes
    localparam alu_op_t ALU_OP_NOP  = 8'h00;
    localparam alu_op_t ALU_OP_ADD  = 8'h01;
    localparam alu_op_t ALU_OP_SUB  = 8'h02;
    localparam alu_op_t ALU_OP_SLT  = 8'h03;
    localparam alu_op_t ALU_OP_SLTU = 8'h04;
    localparam alu_op_t ALU_OP_AND  = 8'h05;
    localparam alu_op_t ALU_OP_OR   = 8'h06;
    localparam alu_op_t ALU_OP_XOR  = 8'h07;
    localparam alu_op_t ALU_OP_LD_W = 8'h08;
    localparam alu_op_t ALU_OP_ST_W = 8'h09;
    localparam alu_op_t ALU_OP_LL   = 8'h0a;
    localparam alu_op_t ALU_OP_SC   = 8'h0b;

    // result class select
    localparam alu_sel_t ALU_SEL_NOP   = 3'd0;
    localparam alu_sel_t ALU_SEL_ARITH = 3'd1;
    localparam alu_sel_t ALU_SEL_LOGIC = 3'd2;
    localparam alu_sel_t ALU_SEL_MOVE  = 3'd3;
    localparam alu_sel_t ALU_SEL_MEM   = 3'd4;

    typedef struct packed {
        pc_t    pc;
        instr_t instr;
    } fetch_pkt_t;

    // one format decoder's verdict, all zero on a miss
    typedef struct packed {
        logic      hit;
        logic      rj_valid;
        logic      rk_valid;
        gpr_addr_t rj;
        gpr_addr_t rk;
        data_t     imm;
        logic      wr_valid;
        gpr_addr_t rd;
        alu_op_t   aluop;
        alu_sel_t  alusel;
    } dec_result_t;

    typedef struct packed {
        pc_t       pc;
        logic      illegal;
        logic      rj_valid;
        logic      rk_valid;
        gpr_addr_t rj;
        gpr_addr_t rk;
        data_t     imm;
        logic      wr_valid;
        gpr_addr_t rd;
        alu_op_t   aluop;
        alu_sel_t  alusel;
    } decoded_pkt_t;

endpackage

`default_nettype wire

// ==== rtl/decode_top.sv ====
`default_nettype none

module decode_top #(
    parameter int BUF_DEPTH = 2
) (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     fetch_valid_i,
    input  decode_pkg::fetch_pkt_t   fetch_pkt_i,
    output logic                     fetch_ready_o,
    output logic                     dec_valid_o,
    output decode_pkg::decoded_pkt_t dec_pkt_o,
    input  logic                     dec_ready_i
);

    import decode_pkg::*;

    logic        head_valid;
    logic        head_ready;
    fetch_pkt_t  head_pkt;
    dec_result_t res_2ri14;
    dec_result_t res_2ri12;
    dec_result_t res_3r;

    instr_buffer #(
        .BUF_DEPTH(BUF_DEPTH)
    ) u_instr_buffer (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (fetch_valid_i),
        .in_pkt_i    (fetch_pkt_i),
        .in_ready_o  (fetch_ready_o),
        .head_valid_o(head_valid),
        .head_pkt_o  (head_pkt),
        .head_ready_i(head_ready)
    );

    // the three formats decode the buffer head in parallel
    decoder_2ri14 u_decoder_2ri14 (
        .instr_i (head_pkt.instr),
        .result_o(res_2ri14)
    );

    decoder_2ri12 u_decoder_2ri12 (
        .instr_i (head_pkt.instr),
        .result_o(res_2ri12)
    );

    decoder_3r u_decoder_3r (
        .instr_i (head_pkt.instr),
        .result_o(res_3r)
    );

    decode_output_stage u_decode_output_stage (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .head_valid_i(head_valid),
        .head_pc_i   (head_pkt.pc),
        .res_2ri14_i (res_2ri14),
        .res_2ri12_i (res_2ri12),
        .res_3r_i    (res_3r),
        .head_ready_o(head_ready),
        .dec_valid_o (dec_valid_o),
        .dec_pkt_o   (dec_pkt_o),
        .dec_ready_i (dec_ready_i)
    );

endmodule

`default_nettype wire

// ==== rtl/decoder_2ri12.sv ====
`default_nettype none

`include "la32_opcodes.svh"

// 2RI12 layout: opcode[31:22] imm12[21:10] rj[9:5] rd[4:0]
module decoder_2ri12 (
    input  decode_pkg::instr_t      instr_i,
    output decode_pkg::dec_result_t result_o
);

    import decode_pkg::*;

    gpr_addr_t   rd;
    gpr_addr_t   rj;
    logic [11:0] imm_12;
    data_t       imm_sext;
    data_t       imm_zext;

    assign rd       = instr_i[4:0];
    assign rj       = instr_i[9:5];
    assign imm_12   = instr_i[21:10];
    assign imm_sext = {{20{imm_12[11]}}, imm_12};
    assign imm_zext = {20'b0, imm_12};

    always_comb begin
        result_o = '0;
        // defaults shared by every hit, cleared again on a miss
        result_o.hit      = 1'b1;
        result_o.rj_valid = 1'b1;
        result_o.rj       = rj;
        result_o.wr_valid = 1'b1;
        result_o.rd       = rd;
        result_o.imm      = imm_sext;
        case (instr_i[31:22])
            `LA32_OP_ADDI_W: begin
                result_o.aluop  = ALU_OP_ADD;
                result_o.alusel = ALU_SEL_ARITH;
            end
            `LA32_OP_SLTI: begin
                result_o.aluop  = ALU_OP_SLT;
                result_o.alusel = ALU_SEL_ARITH;
            end
            `LA32_OP_SLTUI: begin
                result_o.aluop  = ALU_OP_SLTU;
                result_o.alusel = ALU_SEL_ARITH;
            end
            // logic ops take the immediate unsigned
            `LA32_OP_ANDI: begin
                result_o.imm    = imm_zext;
                result_o.aluop  = ALU_OP_AND;
                result_o.alusel = ALU_SEL_LOGIC;
            end
            `LA32_OP_ORI: begin
                result_o.imm    = imm_zext;
                result_o.aluop  = ALU_OP_OR;
                result_o.alusel = ALU_SEL_LOGIC;
            end
            `LA32_OP_XORI: begin
                result_o.imm    = imm_zext;
                result_o.aluop  = ALU_OP_XOR;
                result_o.alusel = ALU_SEL_LOGIC;
            end
            `LA32_OP_LD_W: begin
                result_o.aluop  = ALU_OP_LD_W;
                result_o.alusel = ALU_SEL_MEM;
            end
            `LA32_OP_ST_W: begin
                // rd is the store source here, not a destination
                result_o.wr_valid = 1'b0;
                result_o.rd       = '0;
                result_o.rk_valid = 1'b1;
                result_o.rk       = rd;
                result_o.aluop    = ALU_OP_ST_W;
                result_o.alusel   = ALU_SEL_MEM;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/decoder_2ri14.sv ====
`default_nettype none

`include "la32_opcodes.svh"

// 2RI14 layout: opcode[31:24] imm14[23:10] rj[9:5] rd[4:0]
module decoder_2ri14 (
    input  decode_pkg::instr_t      instr_i,
    output decode_pkg::dec_result_t result_o
);

    import decode_pkg::*;

    gpr_addr_t   rd;
    gpr_addr_t   rj;
    logic [13:0] imm_14;
    data_t       imm_ext;

    assign rd     = instr_i[4:0];
    assign rj     = instr_i[9:5];
    assign imm_14 = instr_i[23:10];
    // word offset, sign extended then scaled by 4
    assign imm_ext = {{16{imm_14[13]}}, imm_14, 2'b00};

    always_comb begin
        result_o = '0;
        case (instr_i[31:24])
            `LA32_OP_LL_W: begin
                result_o.hit      = 1'b1;
                result_o.rj_valid = 1'b1;
                result_o.rj       = rj;
                result_o.imm      = imm_ext;
                result_o.wr_valid = 1'b1;
                result_o.rd       = rd;
                result_o.aluop    = ALU_OP_LL;
                result_o.alusel   = ALU_SEL_MOVE;
            end
            `LA32_OP_SC_W: begin
                result_o.hit      = 1'b1;
                result_o.rj_valid = 1'b1;
                result_o.rj       = rj;
                // store data comes from rd, carried in the rk slot
                result_o.rk_valid = 1'b1;
                result_o.rk       = rd;
                result_o.imm      = imm_ext;
                result_o.aluop    = ALU_OP_SC;
                result_o.alusel   = ALU_SEL_MEM;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/decoder_3r.sv ====
`default_nettype none

`include "la32_opcodes.svh"

// 3R layout: opcode[31:15] rk[14:10] rj[9:5] rd[4:0]
module decoder_3r (
    input  decode_pkg::instr_t      instr_i,
    output decode_pkg::dec_result_t result_o
);

    import decode_pkg::*;

    gpr_addr_t rd;
    gpr_addr_t rj;
    gpr_addr_t rk;
    logic      match;
    alu_op_t   aluop;
    alu_sel_t  alusel;

    assign rd = instr_i[4:0];
    assign rj = instr_i[9:5];
    assign rk = instr_i[14:10];

    // opcode to alu code lookup
    always_comb begin
        match  = 1'b1;
        aluop  = ALU_OP_NOP;
        alusel = ALU_SEL_NOP;
        case (instr_i[31:15])
            `LA32_OP_ADD_W: begin
                aluop  = ALU_OP_ADD;
                alusel = ALU_SEL_ARITH;
            end
            `LA32_OP_SUB_W: begin
                aluop  = ALU_OP_SUB;
                alusel = ALU_SEL_ARITH;
            end
            `LA32_OP_SLT: begin
                aluop  = ALU_OP_SLT;
                alusel = ALU_SEL_ARITH;
            end
            `LA32_OP_SLTU: begin
                aluop  = ALU_OP_SLTU;
                alusel = ALU_SEL_ARITH;
            end
            `LA32_OP_AND: begin
                aluop  = ALU_OP_AND;
                alusel = ALU_SEL_LOGIC;
            end
            `LA32_OP_OR: begin
                aluop  = ALU_OP_OR;
                alusel = ALU_SEL_LOGIC;
            end
            `LA32_OP_XOR: begin
                aluop  = ALU_OP_XOR;
                alusel = ALU_SEL_LOGIC;
            end
            default: begin
                match = 1'b0;
            end
        endcase
    end

    // all three registers used, no immediate
    always_comb begin
        result_o = '0;
        if (match) begin
            result_o.hit      = 1'b1;
            result_o.rj_valid = 1'b1;
            result_o.rk_valid = 1'b1;
            result_o.rj       = rj;
            result_o.rk       = rk;
            result_o.wr_valid = 1'b1;
            result_o.rd       = rd;
            result_o.aluop    = aluop;
            result_o.alusel   = alusel;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/instr_buffer.sv ====
`default_nettype none

// BUF_DEPTH is a power of two, at least 2
module instr_buffer #(
    parameter int BUF_DEPTH = 2
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   in_valid_i,
    input  decode_pkg::fetch_pkt_t in_pkt_i,
    output logic                   in_ready_o,
    output logic                   head_valid_o,
    output decode_pkg::fetch_pkt_t head_pkt_o,
    input  logic                   head_ready_i
);

    import decode_pkg::*;

    localparam int IDX_W = $clog2(BUF_DEPTH);

    fetch_pkt_t     mem [BUF_DEPTH];
    // extra msb tells full from empty
    logic [IDX_W:0] wr_ptr;
    logic [IDX_W:0] rd_ptr;
    logic           empty;
    logic           full;
    logic           push;
    logic           pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[IDX_W] != rd_ptr[IDX_W]) &&
                   (wr_ptr[IDX_W-1:0] == rd_ptr[IDX_W-1:0]);

    assign in_ready_o   = !full;
    assign head_valid_o = !empty;
    assign head_pkt_o   = mem[rd_ptr[IDX_W-1:0]];

    assign push = in_valid_i && in_ready_o;
    assign pop  = head_valid_o && head_ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr[IDX_W-1:0]] <= in_pkt_i;
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f \
    --top-module decode_tb \
    -Mdir obj_dir -o decode_sim

./obj_dir/decode_sim | tee sim.log

if grep -q "No errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== tb/decode_tb.sv ====
`default_nettype none

module decode_tb;

    import decode_pkg::*;

    localparam int BUF_DEPTH = 2;

    logic         clk_i;
    logic         rst_n_i;
    logic         fetch_valid_i;
    fetch_pkt_t   fetch_pkt_i;
    logic         fetch_ready_o;
    logic         dec_valid_o;
    decoded_pkt_t dec_pkt_o;
    logic         dec_ready_i;

    // test table, one slot per entry in all three queues
    string        names[$];
    fetch_pkt_t   stim[$];
    decoded_pkt_t expect_q[$];

    logic [31:0]  lfsr;
    int           errors;
    int           passes;
    int           cycles;
    int           limit;

    decode_top #(
        .BUF_DEPTH(BUF_DEPTH)
    ) uut (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .fetch_valid_i(fetch_valid_i),
        .fetch_pkt_i  (fetch_pkt_i),
        .fetch_ready_o(fetch_ready_o),
        .dec_valid_o  (dec_valid_o),
        .dec_pkt_o    (dec_pkt_o),
        .dec_ready_i  (dec_ready_i)
    );

    always #10 clk_i = ~clk_i;

    // watchdog, limit is set once the table is built
    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout after %0d cycles, the pipeline stopped delivering", cycles);
            $display("Errors found");
            $finish;
        end
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic take_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b = lfsr[0];
    endtask

    function automatic instr_t enc_2ri14(input logic [7:0] op, input logic [13:0] imm,
                                         input gpr_addr_t rj, input gpr_addr_t rd);
        return {op, imm, rj, rd};
    endfunction

    function automatic instr_t enc_2ri12(input logic [9:0] op, input logic [11:0] imm,
                                         input gpr_addr_t rj, input gpr_addr_t rd);
        return {op, imm, rj, rd};
    endfunction

    function automatic instr_t enc_3r(input logic [16:0] op, input gpr_addr_t rk,
                                      input gpr_addr_t rj, input gpr_addr_t rd);
        return {op, rk, rj, rd};
    endfunction

    task automatic add_entry(input string name, input instr_t instr, input logic rjv,
                             input logic rkv, input gpr_addr_t rj, input gpr_addr_t rk,
                             input data_t imm, input logic wrv, input gpr_addr_t rd,
                             input alu_op_t op, input alu_sel_t sel);
        fetch_pkt_t   f;
        decoded_pkt_t e;
        f.pc       = 32'h1c00_0000 + 32'(stim.size() * 4);
        f.instr    = instr;
        e          = '0;
        e.pc       = f.pc;
        e.rj_valid = rjv;
        e.rk_valid = rkv;
        e.rj       = rj;
        e.rk       = rk;
        e.imm      = imm;
        e.wr_valid = wrv;
        e.rd       = rd;
        e.aluop    = op;
        e.alusel   = sel;
        names.push_back(name);
        stim.push_back(f);
        expect_q.push_back(e);
    endtask

    // unknown word: only pc and the illegal flag survive
    task automatic add_illegal(input string name, input instr_t instr);
        decoded_pkt_t e;
        add_entry(name, instr, 0, 0, 0, 0, 0, 0, 0, ALU_OP_NOP, ALU_SEL_NOP);
        e = expect_q.pop_back();
        e.illegal = 1'b1;
        expect_q.push_back(e);
    endtask

    task automatic build_table();
        add_entry("ll_w_pos", enc_2ri14(8'h20, 14'h0010, 5'd3, 5'd4),
                  1, 0, 5'd3, 5'd0, 32'h0000_0040, 1, 5'd4, ALU_OP_LL, ALU_SEL_MOVE);
        add_entry("ll_w_neg", enc_2ri14(8'h20, 14'h3ffe, 5'd5, 5'd6),
                  1, 0, 5'd5, 5'd0, 32'hffff_fff8, 1, 5'd6, ALU_OP_LL, ALU_SEL_MOVE);
        add_entry("sc_w_pos", enc_2ri14(8'h21, 14'h0005, 5'd7, 5'd8),
                  1, 1, 5'd7, 5'd8, 32'h0000_0014, 0, 5'd0, ALU_OP_SC, ALU_SEL_MEM);
        add_entry("sc_w_neg", enc_2ri14(8'h21, 14'h2000, 5'd1, 5'd2),
                  1, 1, 5'd1, 5'd2, 32'hffff_8000, 0, 5'd0, ALU_OP_SC, ALU_SEL_MEM);
        add_entry("addi_w", enc_2ri12(10'h00a, 12'h800, 5'd9, 5'd10),
                  1, 0, 5'd9, 5'd0, 32'hffff_f800, 1, 5'd10, ALU_OP_ADD, ALU_SEL_ARITH);
        add_entry("slti", enc_2ri12(10'h008, 12'h7ff, 5'd11, 5'd12),
                  1, 0, 5'd11, 5'd0, 32'h0000_07ff, 1, 5'd12, ALU_OP_SLT, ALU_SEL_ARITH);
        add_entry("sltui", enc_2ri12(10'h009, 12'hfff, 5'd13, 5'd14),
                  1, 0, 5'd13, 5'd0, 32'hffff_ffff, 1, 5'd14, ALU_OP_SLTU, ALU_SEL_ARITH);
        add_entry("andi", enc_2ri12(10'h00d, 12'h800, 5'd15, 5'd16),
                  1, 0, 5'd15, 5'd0, 32'h0000_0800, 1, 5'd16, ALU_OP_AND, ALU_SEL_LOGIC);
        add_entry("ori", enc_2ri12(10'h00e, 12'h123, 5'd17, 5'd18),
                  1, 0, 5'd17, 5'd0, 32'h0000_0123, 1, 5'd18, ALU_OP_OR, ALU_SEL_LOGIC);
        add_entry("xori", enc_2ri12(10'h00f, 12'hfff, 5'd19, 5'd20),
                  1, 0, 5'd19, 5'd0, 32'h0000_0fff, 1, 5'd20, ALU_OP_XOR, ALU_SEL_LOGIC);
        add_entry("ld_w", enc_2ri12(10'h0a2, 12'hffc, 5'd21, 5'd22),
                  1, 0, 5'd21, 5'd0, 32'hffff_fffc, 1, 5'd22, ALU_OP_LD_W, ALU_SEL_MEM);
        add_entry("st_w", enc_2ri12(10'h0a6, 12'h010, 5'd23, 5'd24),
                  1, 1, 5'd23, 5'd24, 32'h0000_0010, 0, 5'd0, ALU_OP_ST_W, ALU_SEL_MEM);
        add_entry("add_w", enc_3r(17'h00020, 5'd1, 5'd2, 5'd3),
                  1, 1, 5'd2, 5'd1, 32'h0, 1, 5'd3, ALU_OP_ADD, ALU_SEL_ARITH);
        add_entry("sub_w", enc_3r(17'h00022, 5'd4, 5'd5, 5'd6),
                  1, 1, 5'd5, 5'd4, 32'h0, 1, 5'd6, ALU_OP_SUB, ALU_SEL_ARITH);
        add_entry("slt", enc_3r(17'h00024, 5'd7, 5'd8, 5'd9),
                  1, 1, 5'd8, 5'd7, 32'h0, 1, 5'd9, ALU_OP_SLT, ALU_SEL_ARITH);
        add_entry("sltu", enc_3r(17'h00025, 5'd10, 5'd11, 5'd12),
                  1, 1, 5'd11, 5'd10, 32'h0, 1, 5'd12, ALU_OP_SLTU, ALU_SEL_ARITH);
        add_entry("and", enc_3r(17'h00029, 5'd13, 5'd14, 5'd15),
                  1, 1, 5'd14, 5'd13, 32'h0, 1, 5'd15, ALU_OP_AND, ALU_SEL_LOGIC);
        add_entry("or", enc_3r(17'h0002a, 5'd16, 5'd17, 5'd18),
                  1, 1, 5'd17, 5'd16, 32'h0, 1, 5'd18, ALU_OP_OR, ALU_SEL_LOGIC);
        add_entry("xor", enc_3r(17'h0002b, 5'd31, 5'd30, 5'd29),
                  1, 1, 5'd30, 5'd31, 32'h0, 1, 5'd29, ALU_OP_XOR, ALU_SEL_LOGIC);
        add_illegal("ill_ones", 32'hffff_ffff);
        add_illegal("ill_zero", 32'h0000_0000);
        // neighbours of valid opcodes in each format
        add_illegal("ill_2ri14_adj", 32'h2200_0000);
        add_illegal("ill_2ri12_adj", enc_2ri12(10'h00c, 12'h001, 5'd1, 5'd1));
        add_illegal("ill_3r_adj", enc_3r(17'h00021, 5'd1, 5'd2, 5'd3));
    endtask

    // monitor check of one packet that leaves on the next edge
    task automatic check_output(input int idx);
        logic ok;
        ok = (dec_pkt_o === expect_q[idx]);
        assert (ok) else begin
            $display("error %s: expected %h, actual %h",
                     names[idx], expect_q[idx], dec_pkt_o);
            errors++;
        end
        if (ok) begin
            $display("ok %s", names[idx]);
            passes++;
        end
    endtask

    initial begin
        int   tx_idx;
        int   rx_idx;
        int   latency;
        logic fetch_xfer;
        logic bit_v;
        clk_i         = 1'b0;
        rst_n_i       = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_pkt_i   = '0;
        dec_ready_i   = 1'b0;
        lfsr          = 32'hc40c_c5b9;
        errors        = 0;
        passes        = 0;
        cycles        = 0;
        limit         = 0;
        build_table();
        limit = names.size() * 40;
        repeat (4) @(negedge clk_i);
        rst_n_i = 1'b1;
        assert (fetch_ready_o && !dec_valid_o) else begin
            $display("wrong state after reset: fetch_ready_o %b, dec_valid_o %b",
                     fetch_ready_o, dec_valid_o);
            errors++;
        end

        // random back-pressure and idle input over the whole table
        tx_idx     = 0;
        rx_idx     = 0;
        fetch_xfer = 1'b0;
        while (rx_idx < names.size()) begin
            @(negedge clk_i);
            take_bit(bit_v);
            dec_ready_i = bit_v;
            if (dec_valid_o && dec_ready_i) begin
                check_output(rx_idx);
                rx_idx++;
            end
            if (fetch_xfer) begin
                tx_idx++;
                fetch_valid_i = 1'b0;
            end
            // a word already offered is held until it is taken
            if (!fetch_valid_i && tx_idx < names.size()) begin
                take_bit(bit_v);
                if (bit_v) begin
                    fetch_valid_i = 1'b1;
                    fetch_pkt_i   = stim[tx_idx];
                end
            end
            fetch_xfer = fetch_valid_i && fetch_ready_o;
        end
        fetch_valid_i = 1'b0;
        dec_ready_i   = 1'b1;
        repeat (2) @(negedge clk_i);
        assert (!dec_valid_o) else begin
            $display("an extra packet came out after the last table entry");
            errors++;
        end

        // latency of one word through an empty pipeline
        fetch_pkt_i   = stim[0];
        fetch_valid_i = 1'b1;
        assert (fetch_ready_o) else begin
            $display("fetch_ready_o is low although the pipeline is empty");
            errors++;
        end
        latency = 0;
        do begin
            @(negedge clk_i);
            fetch_valid_i = 1'b0;
            latency++;
        end while (!dec_valid_o && latency < 8);
        assert (latency == 2) else begin
            $display("error latency: expected 2, actual %0d", latency);
            errors++;
        end
        if (latency == 2) begin
            $display("ok latency");
            passes++;
        end

        @(negedge clk_i);
        $display("%0d checks passed, %0d failed", passes, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
